// File: logic/soc_pkg.sv
// ----------------------------------------------------------------------
// Shared widths, memory map base and request/response structs for the
// banked memory subsystem
// ----------------------------------------------------------------------

package soc_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  // One enable per byte of a data word
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ----------------------------------------------------------------------
  // Memory map
  // ----------------------------------------------------------------------
  // Start of bank 0, banks follow back to back
  localparam addr_t MemBase = 32'h8000_0000;

  // ----------------------------------------------------------------------
  // Request and response
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic  we;
    addr_t addr;
    strb_t strb;
    data_t wdata;
  } mem_req_t;

  // Error flag marks a decode miss
  typedef struct packed {
    logic  err;
    data_t rdata;
  } mem_rsp_t;

endpackage

// File: logic/addr_decode.sv
// ----------------------------------------------------------------------
// Address decoder that maps a request onto one bank or flags a miss
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module addr_decode #(
  parameter int unsigned NumBanks  = 4,
  parameter int unsigned BankWords = 256
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  soc_pkg::mem_req_t  req_i,
  output logic [NumBanks-1:0] bank_req_o,
  output soc_pkg::mem_req_t  bank_req_payload_o,
  output logic               miss_o
);

  import soc_pkg::*;

  localparam int unsigned ByteBits = $clog2(StrbWidth);
  localparam int unsigned IdxWidth = (BankWords > 1) ? $clog2(BankWords) : 1;
  // Byte offset bits covered by a single bank
  localparam int unsigned BankBits = IdxWidth + ByteBits;
  localparam int unsigned MapBytes = NumBanks * BankWords * StrbWidth;

  addr_t offset;
  addr_t bank_sel;
  addr_t word_idx;
  logic  in_range;

  // Below MemBase the subtraction wraps and lands out of range
  assign offset   = req_i.addr - MemBase;
  assign in_range = (offset < addr_t'(MapBytes));
  assign bank_sel = offset >> BankBits;
  assign word_idx = (offset >> ByteBits) & addr_t'(BankWords - 1);

  always_comb begin
    bank_req_o = '0;
    for (int unsigned k = 0; k < NumBanks; k++) begin
      bank_req_o[k] = req_valid_i && in_range && (bank_sel == addr_t'(k));
    end
  end

  // Payload is shared by all banks and only the strobe selects one
  always_comb begin
    bank_req_payload_o      = req_i;
    bank_req_payload_o.addr = word_idx;
  end

  assign miss_o = req_valid_i && !in_range;

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------
  a_one_target : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bank_req_o, miss_o}) && ((|{bank_req_o, miss_o}) == req_valid_i)
  ) else $error("request did not reach exactly one target");

endmodule

// File: logic/sram_bank.sv
// ----------------------------------------------------------------------
// Single SRAM bank with byte-enable writes and a registered read port
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned BankWords = 256
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  soc_pkg::mem_req_t req_payload_i,
  output logic              rsp_valid_o,
  output soc_pkg::data_t    rdata_o
);

  import soc_pkg::*;

  localparam int unsigned IdxWidth  = (BankWords > 1) ? $clog2(BankWords) : 1;
  localparam int unsigned ByteWidth = DataWidth / StrbWidth;

  data_t               mem_q [BankWords];
  data_t               rdata_q;
  logic                valid_q;
  logic [IdxWidth-1:0] idx;

  assign idx = req_payload_i.addr[IdxWidth-1:0];

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && req_payload_i.we) begin
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        if (req_payload_i.strb[b]) begin
          mem_q[idx][b*ByteWidth +: ByteWidth] <= req_payload_i.wdata[b*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= req_payload_i.we ? '0 : mem_q[idx];
    end
  end

  // Response strobe, one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rdata_o     = rdata_q;

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------
  a_idx_in_bank : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (req_payload_i.addr < addr_t'(BankWords))
  ) else $error("word index beyond bank depth");

endmodule

// File: logic/resp_mux.sv
// ----------------------------------------------------------------------
// Response mux: merges bank responses and delayed misses into one
// response stream
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module resp_mux #(
  parameter int unsigned NumBanks = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumBanks-1:0] bank_valid_i,
  input  soc_pkg::data_t      bank_rdata_i [NumBanks],
  input  logic                miss_i,
  output logic                rsp_valid_o,
  output soc_pkg::mem_rsp_t   rsp_o
);

  import soc_pkg::*;

  logic  miss_q;
  data_t sel_rdata;

  // Miss delayed by one cycle to match bank latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_q <= 1'b0;
    end else begin
      miss_q <= miss_i;
    end
  end

  // AND-OR select, at most one bank valid
  always_comb begin
    sel_rdata = '0;
    for (int unsigned k = 0; k < NumBanks; k++) begin
      if (bank_valid_i[k]) begin
        sel_rdata = sel_rdata | bank_rdata_i[k];
      end
    end
  end

  assign rsp_valid_o = (|bank_valid_i) || miss_q;
  assign rsp_o.err   = miss_q;
  // Zero on a miss since no bank is valid then
  assign rsp_o.rdata = sel_rdata;

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------
  a_single_source : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bank_valid_i, miss_q})
  ) else $error("more than one response source in one cycle");

endmodule

// File: logic/debug_gate.sv
// ----------------------------------------------------------------------
// Debug request gate: blocks debug requests during a startup window
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module debug_gate #(
  parameter int unsigned DelCycles = 16
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  output logic dbg_req_o
);

  localparam int unsigned CntWidth = (DelCycles > 0) ? $clog2(DelCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] cnt_d;
  logic                cnt_done;

  // Saturating down-counter
  assign cnt_done = (cnt_q == '0);
  assign cnt_d    = cnt_done ? '0 : cnt_q - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DelCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Lets boot code run before the first debug request can interrupt it
  assign dbg_req_o = cnt_done ? dbg_req_i : 1'b0;

endmodule

// File: logic/mem_subsys_top.sv
// ----------------------------------------------------------------------
// Memory subsystem top: address decoder, SRAM bank array, response mux
// and debug startup gate
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int unsigned NumBanks  = 4,
  parameter int unsigned BankWords = 256,
  parameter int unsigned DelCycles = 16
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  soc_pkg::mem_req_t req_i,
  output logic              rsp_valid_o,
  output soc_pkg::mem_rsp_t rsp_o,
  input  logic              dbg_req_i,
  output logic              dbg_req_o
);

  import soc_pkg::*;

  logic [NumBanks-1:0] bank_req;
  mem_req_t            bank_payload;
  logic                miss;
  logic [NumBanks-1:0] bank_valid;
  data_t               bank_rdata [NumBanks];

  // ----------------------------------------------------------------------
  // Request path
  // ----------------------------------------------------------------------
  addr_decode #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords )
  ) i_addr_decode (
    .clk_i              ( clk_i        ),
    .rst_ni             ( rst_ni       ),
    .req_valid_i        ( req_valid_i  ),
    .req_i              ( req_i        ),
    .bank_req_o         ( bank_req     ),
    .bank_req_payload_o ( bank_payload ),
    .miss_o             ( miss         )
  );

  for (genvar k = 0; k < NumBanks; k++) begin : g_bank
    sram_bank #(
      .BankWords ( BankWords )
    ) i_sram_bank (
      .clk_i         ( clk_i         ),
      .rst_ni        ( rst_ni        ),
      .req_i         ( bank_req[k]   ),
      .req_payload_i ( bank_payload  ),
      .rsp_valid_o   ( bank_valid[k] ),
      .rdata_o       ( bank_rdata[k] )
    );
  end

  // ----------------------------------------------------------------------
  // Response path
  // ----------------------------------------------------------------------
  resp_mux #(
    .NumBanks ( NumBanks )
  ) i_resp_mux (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .bank_valid_i ( bank_valid  ),
    .bank_rdata_i ( bank_rdata  ),
    .miss_i       ( miss        ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_o        ( rsp_o       )
  );

  // Debug startup window
  debug_gate #(
    .DelCycles ( DelCycles )
  ) i_debug_gate (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .dbg_req_i ( dbg_req_i ),
    .dbg_req_o ( dbg_req_o )
  );

endmodule

// File: tb/tb_clk_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and active-low reset generator
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 5,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Release on a rising edge, after ResetCycles edges in reset
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: tb/tb_top.sv
// ----------------------------------------------------------------------
// Testbench for the memory subsystem: directed tests against a
// reference memory model, response timing and debug startup window
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_top;

  import soc_pkg::*;

  localparam int unsigned NumBanks   = 4;
  localparam int unsigned BankWords  = 256;
  localparam int unsigned DelCycles  = 16;
  localparam int unsigned RspTimeout = 20;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  mem_req_t req;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     dbg_req_in;
  logic     dbg_req_out;

  int unsigned errors;
  int unsigned checks;
  int unsigned cycles_since_reset = 0;

  // Expected memory contents, keyed by word-aligned byte address
  data_t model_mem [addr_t];
  // One written word per bank, used for the back-to-back reads
  addr_t bank_addr [NumBanks];

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  mem_subsys_top #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords ),
    .DelCycles ( DelCycles )
  ) dut (
    .clk_i       ( clk         ),
    .rst_ni      ( rst_n       ),
    .req_valid_i ( req_valid   ),
    .req_i       ( req         ),
    .rsp_valid_o ( rsp_valid   ),
    .rsp_o       ( rsp         ),
    .dbg_req_i   ( dbg_req_in  ),
    .dbg_req_o   ( dbg_req_out )
  );

  always @(posedge clk) begin
    if (rst_n) begin
      cycles_since_reset <= cycles_since_reset + 1;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic addr_t bank_base(input int unsigned k);
    return MemBase + addr_t'(k * BankWords * StrbWidth);
  endfunction

  function automatic data_t random_data();
    return {$urandom, $urandom};
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata,
                                        input strb_t strb);
    data_t word;
    word = old;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return word;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s: expected %h, got %h", $time, what, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_for_reset();
    int unsigned guard;
    guard = 0;
    while (rst_n !== 1'b1 && guard < 20) begin
      @(negedge clk);
      guard++;
    end
    if (rst_n !== 1'b1) begin
      $display("ERROR at %0t: reset was never released", $time);
      errors++;
    end
  endtask

  // One request, then wait for its single response
  task automatic issue_access(input logic we, input addr_t addr, input strb_t strb,
                              input data_t wdata, output mem_rsp_t got);
    int unsigned lat;
    bit          seen;
    lat  = 0;
    seen = 1'b0;
    got  = 'x;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{we: we, addr: addr, strb: strb, wdata: wdata};
    @(posedge clk);
    req_valid <= 1'b0;
    while (!seen && lat < RspTimeout) begin
      @(negedge clk);
      lat++;
      if (rsp_valid) begin
        seen = 1'b1;
        got  = rsp;
      end
    end
    if (!seen) begin
      $display("ERROR at %0t: no response arrived for address %h within %0d cycles",
               $time, addr, RspTimeout);
      errors++;
    end else begin
      check_value(64'(lat), 64'd1, "response latency in cycles");
    end
  endtask

  task automatic write_word(input addr_t addr, input strb_t strb, input data_t wdata);
    mem_rsp_t got;
    data_t    old;
    issue_access(1'b1, addr, strb, wdata, got);
    check_value(64'(got.err), 64'd0, "error flag on write");
    check_value(got.rdata, 64'd0, "read data on write");
    old = model_mem.exists(addr) ? model_mem[addr] : '0;
    model_mem[addr] = merge_bytes(old, wdata, strb);
  endtask

  task automatic read_and_compare(input addr_t addr, input string what);
    mem_rsp_t got;
    issue_access(1'b0, addr, '0, '0, got);
    check_value(64'(got.err), 64'd0, {what, ": error flag"});
    check_value(got.rdata, model_mem[addr], {what, ": read data"});
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_idle_after_reset();
    int unsigned guard;
    guard = 0;
    while (cycles_since_reset < DelCycles - 2 && guard < DelCycles) begin
      check_value(64'(rsp_valid), 64'd0, "rsp_valid_o while idle");
      check_value(64'(dbg_req_out), 64'd0, "dbg_req_o inside startup window");
      @(negedge clk);
      guard++;
    end
    if (cycles_since_reset < DelCycles - 2) begin
      $display("ERROR at %0t: cycle counter did not advance after reset", $time);
      errors++;
    end
  endtask

  task automatic test_write_read_banks();
    addr_t addr;
    data_t wdata;
    for (int unsigned k = 0; k < NumBanks; k++) begin
      addr  = bank_base(k) + addr_t'($urandom_range(BankWords - 1) * StrbWidth);
      wdata = random_data();
      bank_addr[k] = addr;
      write_word(addr, '1, wdata);
      read_and_compare(addr, "full write then read");
    end
  endtask

  task automatic test_partial_strobe();
    addr_t addr;
    for (int i = 0; i < 4; i++) begin
      addr = bank_base(i % NumBanks) + addr_t'($urandom_range(BankWords - 1) * StrbWidth);
      write_word(addr, '1, random_data());
      write_word(addr, strb_t'($urandom), random_data());
      write_word(addr, 8'h5a, random_data());
      read_and_compare(addr, "partial strobe merge");
    end
  endtask

  task automatic test_out_of_map();
    addr_t    miss_addr [4];
    mem_rsp_t got;
    miss_addr[0] = MemBase - addr_t'(StrbWidth);
    miss_addr[1] = bank_base(NumBanks);
    miss_addr[2] = 32'h0000_0100;
    miss_addr[3] = 32'hffff_fff8;
    foreach (miss_addr[i]) begin
      issue_access(1'b0, miss_addr[i], '0, '0, got);
      check_value(64'(got.err), 64'd1, "error flag on unmapped read");
      check_value(got.rdata, 64'd0, "data on unmapped read");
      issue_access(1'b1, miss_addr[i], '1, random_data(), got);
      check_value(64'(got.err), 64'd1, "error flag on unmapped write");
      check_value(got.rdata, 64'd0, "data on unmapped write");
    end
    // Nothing mapped may have changed
    foreach (model_mem[a]) begin
      read_and_compare(a, "reread after unmapped accesses");
    end
  endtask

  task automatic test_back_to_back();
    addr_t       order [$];
    int unsigned n;
    for (int k = 0; k < NumBanks; k++) begin
      order.push_back(bank_addr[k]);
    end
    for (int k = NumBanks - 1; k >= 0; k--) begin
      order.push_back(bank_addr[k]);
    end
    n = order.size();
    // Request c goes out in cycle c, its response is seen in cycle c+1
    for (int unsigned c = 0; c <= n; c++) begin
      @(posedge clk);
      if (c < n) begin
        req_valid <= 1'b1;
        req       <= '{we: 1'b0, addr: order[c], strb: '0, wdata: '0};
      end else begin
        req_valid <= 1'b0;
      end
      @(negedge clk);
      if (c == 0) begin
        check_value(64'(rsp_valid), 64'd0, "early response in back-to-back reads");
      end else begin
        check_value(64'(rsp_valid), 64'd1, "response valid in back-to-back reads");
        check_value(64'(rsp.err), 64'd0, "error flag in back-to-back reads");
        check_value(rsp.rdata, model_mem[order[c-1]], "data in back-to-back reads");
      end
    end
    @(negedge clk);
    check_value(64'(rsp_valid), 64'd0, "extra response after back-to-back reads");
  endtask

  task automatic test_debug_open();
    int unsigned guard;
    logic        val;
    guard = 0;
    while (cycles_since_reset < DelCycles + 2 && guard < 4 * DelCycles) begin
      @(negedge clk);
      guard++;
    end
    if (cycles_since_reset < DelCycles + 2) begin
      $display("ERROR at %0t: startup window never reached its end", $time);
      errors++;
    end
    for (int v = 0; v < 2; v++) begin
      val = (v == 1);
      @(posedge clk);
      dbg_req_in <= val;
      @(negedge clk);
      check_value(64'(dbg_req_out), 64'(val), "dbg_req_o after startup window");
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'hfb20a57f));
    errors     = 0;
    checks     = 0;
    req_valid  = 1'b0;
    req        = '0;
    dbg_req_in = 1'b1;
    wait_for_reset();
    test_idle_after_reset();
    test_write_read_banks();
    test_partial_strobe();
    test_out_of_map();
    test_back_to_back();
    test_debug_open();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/soc_pkg.sv
logic/addr_decode.sv
logic/sram_bank.sv
logic/resp_mux.sv
logic/debug_gate.sv
logic/mem_subsys_top.sv
tb/tb_clk_gen.sv
tb/tb_top.sv

// File: Makefile
# Verilator flow for the memory subsystem testbench

TOP := tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module mem_subsys_top
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
